// File: Makefile
VERILATOR ?= verilator
TOP       ?= sm83_core_tb
RTL_TOP   ?= sm83_core
FILELIST  ?= sm83_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -Wall -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: rtl/sm83_alu.sv
`timescale 1ns/10ps

module sm83_alu (
	input  logic       clk,
	input  logic       areset,
	input  logic       ready,

	input  logic [2:0] alu_op,
	input  logic       alu_b_imm,
	input  logic       flags_we,
	input  logic [7:0] a_data,
	input  logic [7:0] src_data,
	input  logic [7:0] data_in,

	output logic [7:0] alu_result,
	output logic [7:0] flags,
	output logic       cond_true
);

	import sm83_pkg::*;

	logic [7:0] b;
	logic [8:0] sum;
	logic [7:0] flags_next;
	logic       carry_in;
	logic       is_sub;
	logic       cc_flag;

	assign b        = alu_b_imm ? data_in : src_data;
	assign carry_in = flags[FLAG_C] && (alu_op == ALU_ADC || alu_op == ALU_SBC);
	assign is_sub   = alu_op == ALU_SUB || alu_op == ALU_SBC || alu_op == ALU_CP;

	always_comb begin
		unique case (alu_op)
			ALU_ADD, ALU_ADC:         sum = {1'b0, a_data} + {1'b0, b} + {8'd0, carry_in};
			ALU_SUB, ALU_SBC, ALU_CP: sum = {1'b0, a_data} - {1'b0, b} - {8'd0, carry_in};
			ALU_AND:                  sum = {1'b0, a_data & b};
			ALU_XOR:                  sum = {1'b0, a_data ^ b};
			ALU_OR:                   sum = {1'b0, a_data | b};
		endcase

		flags_next         = 8'h00; // H is not modelled and the low nibble stays zero.
		flags_next[FLAG_Z] = sum[7:0] == 8'h00;
		flags_next[FLAG_N] = is_sub;
		flags_next[FLAG_C] = sum[8]; // Borrow for subtraction, zero for logic.
	end

	assign alu_result = sum[7:0];

	always_ff @(posedge clk) begin
		if (areset) begin
			flags <= 8'h00;
		end else if (ready && flags_we) begin
			flags <= flags_next;
		end
	end

	// cc is NZ, Z, NC, C: bit 1 picks the flag and bit 0 its sense.
	assign cc_flag   = alu_op[1] ? flags[FLAG_C] : flags[FLAG_Z];
	assign cond_true = cc_flag == alu_op[0];

endmodule

// File: rtl/sm83_control.sv
`timescale 1ns/10ps

module sm83_control (
	input  logic              clk,
	input  logic              areset,
	input  logic              ready,
	input  sm83_pkg::opcode_t opcode,
	input  logic              cond_true,

	output logic [2:0]        reg_src_sel,
	output logic [2:0]        reg_dst_sel,
	output logic              reg_we,
	output logic [1:0]        pair_sel,
	output logic              pair_lo_we,
	output logic              pair_hi_we,
	output logic              pc_inc,
	output logic              pc_load,
	output logic              imm_we,
	output logic              adr_sel,

	output logic [2:0]        alu_op,
	output logic              alu_b_imm,
	output logic              flags_we,

	output logic              mem_rd,
	output logic              mem_wr,
	output logic              ir_we,
	output logic              halted
);

	import sm83_pkg::*;

	logic [1:0] m;
	logic [1:0] last_m;
	logic [1:0] x;
	logic [2:0] y;
	logic [2:0] z;
	logic       is_halt;
	logic       ld_r_r;
	logic       st_hl;
	logic       ld_r_d8;
	logic       ld_rr_d16;
	logic       alu_r;
	logic       alu_d8;
	logic       jp;
	logic       fetch;
	logic       operand;

	assign x = opcode.xyz.x;
	assign y = opcode.xyz.y;
	assign z = opcode.xyz.z;

	assign is_halt   = opcode == OP_HALT;
	assign ld_r_r    = x == 2'd1 && y != REG_MEM && z != REG_MEM;
	assign st_hl     = x == 2'd1 && y == REG_MEM && z != REG_MEM;
	assign ld_r_d8   = x == 2'd0 && y != REG_MEM && z == REG_MEM;
	assign ld_rr_d16 = x == 2'd0 && z == 3'd1 && !opcode.xpqz.q;
	assign alu_r     = x == 2'd2 && z != REG_MEM;
	assign alu_d8    = x == 2'd3 && z == REG_MEM;
	assign jp        = opcode == OP_JP || (x == 2'd3 && z == 3'd2 && !y[2]);

	// The last cycle of every instruction also fetches the next opcode.
	always_comb begin
		if (ld_rr_d16 || jp) begin
			last_m = 2'd2;
		end else if (ld_r_d8 || alu_d8 || st_hl) begin
			last_m = 2'd1;
		end else begin
			last_m = 2'd0;
		end
	end

	assign fetch   = m == last_m && !is_halt && !halted;
	assign operand = (ld_r_d8 || alu_d8 || ld_rr_d16 || jp) && m != last_m && !halted;

	assign mem_rd  = fetch || operand;
	assign mem_wr  = st_hl && m == 2'd0 && !halted;
	assign ir_we   = fetch;
	assign pc_inc  = mem_rd; // Every read is at PC.
	assign adr_sel = st_hl && m == 2'd0;

	assign reg_src_sel = z;
	assign reg_dst_sel = (alu_r || alu_d8) ? REG_A : y;
	assign reg_we      = m == 2'd0 &&
		(ld_r_r || ld_r_d8 || ((alu_r || alu_d8) && y != ALU_CP));

	// For JP cc the y field carries the condition code into the ALU.
	assign alu_op    = y;
	assign alu_b_imm = alu_d8;
	assign flags_we  = m == 2'd0 && (alu_r || alu_d8);

	assign pair_sel   = opcode.xpqz.p;
	assign pair_lo_we = ld_rr_d16 && m == 2'd0;
	assign pair_hi_we = ld_rr_d16 && m == 2'd1;

	assign imm_we  = jp && m != last_m;
	assign pc_load = jp && m == 2'd1 && (opcode == OP_JP || cond_true);

	always_ff @(posedge clk) begin
		if (areset) begin
			m      <= 2'd0;
			halted <= 1'b0;
		end else if (ready) begin
			m <= (m == last_m) ? 2'd0 : m + 2'd1;
			if (is_halt) begin
				halted <= 1'b1; // Sticky until reset.
			end
		end
	end

endmodule

// File: rtl/sm83_core.sv
`timescale 1ns/10ps

module sm83_core #(
	parameter logic [15:0] RESET_PC = 16'h0100
) (
	input  logic        clk,
	input  logic        areset,
	input  logic        ready,
	output logic [15:0] adr,
	input  logic [7:0]  din,
	output logic [7:0]  dout,
	output logic        rd,
	output logic        wr,
	output logic        halted
);

	import sm83_pkg::*;

	opcode_t     opcode;
	logic [2:0]  reg_src_sel;
	logic [2:0]  reg_dst_sel;
	logic [1:0]  pair_sel;
	logic [2:0]  alu_op;
	logic        reg_we;
	logic        pair_lo_we;
	logic        pair_hi_we;
	logic        pc_inc;
	logic        pc_load;
	logic        imm_we;
	logic        adr_sel;
	logic        alu_b_imm;
	logic        flags_we;
	logic        mem_rd;
	logic        mem_wr;
	logic        ir_we;
	logic        cond_true;
	logic [15:0] bus_adr;
	logic [7:0]  store_data;
	logic [7:0]  data_in;
	logic [7:0]  src_data;
	logic [7:0]  a_data;
	logic [7:0]  alu_result;
	logic [7:0]  flags;

	sm83_io io0 (
		.clk, .areset, .ready, .mem_rd, .mem_wr, .ir_we, .bus_adr, .store_data, .din,
		.adr, .dout, .rd, .wr, .opcode, .data_in
	);

	sm83_control control0 (
		.clk, .areset, .ready, .opcode, .cond_true,
		.reg_src_sel, .reg_dst_sel, .reg_we, .pair_sel, .pair_lo_we, .pair_hi_we,
		.pc_inc, .pc_load, .imm_we, .adr_sel, .alu_op, .alu_b_imm, .flags_we,
		.mem_rd, .mem_wr, .ir_we, .halted
	);

	sm83_regfile #(.RESET_PC(RESET_PC)) regfile0 (
		.clk, .areset, .ready, .reg_src_sel, .reg_dst_sel, .reg_we, .pair_sel,
		.pair_lo_we, .pair_hi_we, .pc_inc, .pc_load, .imm_we, .adr_sel, .flags_we,
		.data_in, .alu_result, .bus_adr, .src_data, .a_data, .store_data
	);

	sm83_alu alu0 (
		.clk, .areset, .ready, .alu_op, .alu_b_imm, .flags_we, .a_data, .src_data,
		.data_in, .alu_result, .flags, .cond_true
	);

endmodule

// File: rtl/sm83_io.sv
`timescale 1ns/10ps

module sm83_io (
	input  logic              clk,
	input  logic              areset,
	input  logic              ready,

	input  logic              mem_rd,
	input  logic              mem_wr,
	input  logic              ir_we,
	input  logic [15:0]       bus_adr,
	input  logic [7:0]        store_data,
	input  logic [7:0]        din,

	output logic [15:0]       adr,
	output logic [7:0]        dout,
	output logic              rd,
	output logic              wr,
	output sm83_pkg::opcode_t opcode,
	output logic [7:0]        data_in
);

	import sm83_pkg::*;

	assign rd = mem_rd;
	assign wr = mem_wr;

	assign adr = bus_adr;

	// The data pins only carry a register byte during a store.
	assign dout = wr ? store_data : 8'h00;

	assign data_in = din; // Immediates and operands go straight to the datapath.

	always_ff @(posedge clk) begin
		if (areset) begin
			opcode <= OP_NOP;
		end else if (ready && ir_we) begin
			opcode <= din; // Latched at the end of the fetch cycle.
		end
	end

endmodule

// File: rtl/sm83_pkg.sv
package sm83_pkg;

	// One opcode byte, read through the two SM83 decode views.
	typedef union packed {
		struct packed {
			logic [1:0] x;
			logic [2:0] y;
			logic [2:0] z;
		} xyz;
		struct packed {
			logic [1:0] x;
			logic [1:0] p;
			logic       q;
			logic [2:0] z;
		} xpqz;
	} opcode_t;

	localparam logic [2:0] REG_B   = 3'd0;
	localparam logic [2:0] REG_C   = 3'd1;
	localparam logic [2:0] REG_D   = 3'd2;
	localparam logic [2:0] REG_E   = 3'd3;
	localparam logic [2:0] REG_H   = 3'd4;
	localparam logic [2:0] REG_L   = 3'd5;
	localparam logic [2:0] REG_MEM = 3'd6; // Memory operand, (HL) or the immediate byte.
	localparam logic [2:0] REG_A   = 3'd7;

	localparam logic [2:0] ALU_ADD = 3'd0;
	localparam logic [2:0] ALU_ADC = 3'd1;
	localparam logic [2:0] ALU_SUB = 3'd2;
	localparam logic [2:0] ALU_SBC = 3'd3;
	localparam logic [2:0] ALU_AND = 3'd4;
	localparam logic [2:0] ALU_XOR = 3'd5;
	localparam logic [2:0] ALU_OR  = 3'd6;
	localparam logic [2:0] ALU_CP  = 3'd7;

	localparam int FLAG_Z = 7;
	localparam int FLAG_N = 6;
	localparam int FLAG_C = 4;

	localparam logic [7:0] OP_NOP  = 8'h00;
	localparam logic [7:0] OP_HALT = 8'h76;
	localparam logic [7:0] OP_JP   = 8'hc3;

endpackage

// File: rtl/sm83_regfile.sv
`timescale 1ns/10ps

module sm83_regfile #(
	parameter logic [15:0] RESET_PC = 16'h0100
) (
	input  logic        clk,
	input  logic        areset,
	input  logic        ready,

	input  logic [2:0]  reg_src_sel,
	input  logic [2:0]  reg_dst_sel,
	input  logic        reg_we,
	input  logic [1:0]  pair_sel,
	input  logic        pair_lo_we,
	input  logic        pair_hi_we,
	input  logic        pc_inc,
	input  logic        pc_load,
	input  logic        imm_we,
	input  logic        adr_sel,
	input  logic        flags_we,

	input  logic [7:0]  data_in,
	input  logic [7:0]  alu_result,

	output logic [15:0] bus_adr,
	output logic [7:0]  src_data,
	output logic [7:0]  a_data,
	output logic [7:0]  store_data
);

	import sm83_pkg::*;

	logic [7:0]  regs [8];
	logic [15:0] sp;
	logic [15:0] pc;
	logic [15:0] wz;
	logic [15:0] wz_next;
	logic [7:0]  wr_data;

	assign store_data = regs[reg_src_sel];
	assign src_data   = (reg_src_sel == REG_MEM) ? data_in : regs[reg_src_sel];
	assign a_data     = regs[REG_A];
	assign wr_data    = flags_we ? alu_result : src_data;

	// Operand bytes arrive low first, so WZ fills from the top.
	assign wz_next = {data_in, wz[15:8]};

	assign bus_adr = adr_sel ? {regs[REG_H], regs[REG_L]} : pc;

	always_ff @(posedge clk) begin
		if (areset) begin
			for (int i = 0; i < 8; i++) begin
				regs[i] <= 8'h00;
			end
			sp <= 16'h0000;
			wz <= 16'h0000;
			pc <= RESET_PC;
		end else if (ready) begin
			if (reg_we) begin
				regs[reg_dst_sel] <= wr_data;
			end
			if (pair_sel == 2'd3) begin
				if (pair_lo_we) begin
					sp[7:0] <= data_in;
				end
				if (pair_hi_we) begin
					sp[15:8] <= data_in;
				end
			end else begin
				if (pair_lo_we) begin
					regs[{pair_sel, 1'b1}] <= data_in; // C, E or L.
				end
				if (pair_hi_we) begin
					regs[{pair_sel, 1'b0}] <= data_in;
				end
			end
			if (imm_we) begin
				wz <= wz_next;
			end
			if (pc_load) begin
				pc <= wz_next;
			end else if (pc_inc) begin
				pc <= pc + 16'd1;
			end
		end
	end

endmodule

// File: sim/sm83_core_sva.sv
`timescale 1ns/10ps

module sm83_core_sva (
	input logic        clk,
	input logic        areset,
	input logic        ready,
	input logic [15:0] adr,
	input logic        rd,
	input logic        wr,
	input logic        halted
);

	no_overlap: assert property (@(posedge clk) disable iff (areset) !(rd && wr))
		else $error("rd and wr high together");

	// A stalled cycle holds the whole bus.
	stall_hold: assert property (@(posedge clk) disable iff (areset)
		!ready |=> $stable(adr) && $stable(rd) && $stable(wr))
		else $error("bus changed while ready was low");

	halt_quiet: assert property (@(posedge clk) disable iff (areset) halted |-> !rd && !wr)
		else $error("strobe while halted");

endmodule

bind sm83_core sm83_core_sva sva0 (
	.clk(clk), .areset(areset), .ready(ready), .adr(adr), .rd(rd), .wr(wr), .halted(halted)
);

// File: sim/sm83_core_tb.sv
`timescale 1ns/10ps

module sm83_core_tb;

	import sm83_pkg::*;

	localparam logic [15:0] RESET_PC = 16'h0100;
	localparam int N_SLOTS = 160;
	localparam int JUMP_REACH = 6;
	// A store slot holds two instructions, and no instruction takes more than 3 cycles.
	localparam int WATCHDOG_CYCLES = (2 * N_SLOTS + 1) * 3 * 4 + 500;

	logic        clk = 1'b0;
	logic        areset;
	logic        ready;
	logic [15:0] adr;
	logic [7:0]  din;
	logic [7:0]  dout;
	logic        rd;
	logic        wr;
	logic        halted;

	logic [7:0]  mem [65536];
	logic [7:0]  model_mem [65536];
	logic [15:0] slot_adr [N_SLOTS + 1];
	logic [15:0] gen_adr;
	logic [15:0] jump_at [$];
	int          jump_slot [$];

	logic [15:0] exp_adr [$];
	logic        exp_wr [$];
	logic [7:0]  exp_data [$];

	logic [7:0]  m_r [8];
	logic [7:0]  m_f;
	logic [15:0] m_sp;

	int          errors;
	int          reset_count;
	bit          first_done;

	sm83_core dut0 (
		.clk(clk), .areset(areset), .ready(ready), .adr(adr), .din(din),
		.dout(dout), .rd(rd), .wr(wr), .halted(halted)
	);

	always #20 clk = ~clk;

	task automatic check_value(input string name, input logic [15:0] got, input logic [15:0] exp);
		if (got !== exp) begin
			errors++;
			$display("FAILED %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic emit(input logic [7:0] b);
		mem[gen_adr] = b;
		gen_adr = gen_adr + 16'd1;
	endtask

	task automatic build_program;
		int         kind;
		int         t;
		logic [2:0] y;
		logic [2:0] z;
		logic [2:0] op;
		for (int a = 0; a < 65536; a++) begin
			mem[a] = a[7:0] ^ a[15:8] ^ 8'h5a;
		end
		gen_adr = RESET_PC;
		for (int i = 0; i < N_SLOTS; i++) begin
			slot_adr[i] = gen_adr;
			kind = int'($urandom % 10);
			y = 3'($urandom);
			z = 3'($urandom);
			op = 3'($urandom);
			if (y == REG_MEM) y = REG_A;
			if (z == REG_MEM) z = REG_B;
			case (kind)
				0: emit(OP_NOP);
				1: emit({2'b01, y, z});
				2: begin
					emit({2'b00, y, 3'd6});
					emit(8'($urandom));
				end
				3: begin
					emit({2'b00, 2'($urandom), 4'b0001});
					emit(8'($urandom));
					emit(8'($urandom));
				end
				4, 5: emit({2'b10, op, z});
				6: begin
					emit({2'b11, op, 3'd6});
					emit(8'($urandom));
				end
				7: begin
					emit(8'h21); // HL points into a data page far from the code.
					emit(8'($urandom));
					emit(8'hc0);
					emit({5'b01110, z});
				end
				default: begin
					if (kind == 8) begin
						emit(OP_JP);
					end else begin
						emit({3'b110, 2'($urandom), 3'd2});
					end
					t = i + 1 + int'($urandom % JUMP_REACH);
					if (t > N_SLOTS) t = N_SLOTS;
					jump_at.push_back(gen_adr);
					jump_slot.push_back(t);
					emit(8'h00);
					emit(8'h00);
				end
			endcase
		end
		slot_adr[N_SLOTS] = gen_adr;
		emit(OP_HALT);
		// Targets only point forward, so every path reaches the HALT.
		foreach (jump_at[k]) begin
			mem[jump_at[k]] = slot_adr[jump_slot[k]][7:0];
			mem[jump_at[k] + 16'd1] = slot_adr[jump_slot[k]][15:8];
		end
	endtask

	task automatic expect_cycle(input logic [15:0] a, input logic w, input logic [7:0] d);
		exp_adr.push_back(a);
		exp_wr.push_back(w);
		exp_data.push_back(d);
	endtask

	task automatic run_alu(input logic [2:0] op, input logic [7:0] b);
		int         ia;
		int         ib;
		int         ic;
		int         s;
		logic [7:0] res;
		logic       carry;
		logic       sub;
		ia = int'(m_r[REG_A]);
		ib = int'(b);
		ic = (m_f[FLAG_C] && (op == ALU_ADC || op == ALU_SBC)) ? 1 : 0;
		sub = op == ALU_SUB || op == ALU_SBC || op == ALU_CP;
		carry = 1'b0;
		if (op == ALU_AND) begin
			res = m_r[REG_A] & b;
		end else if (op == ALU_XOR) begin
			res = m_r[REG_A] ^ b;
		end else if (op == ALU_OR) begin
			res = m_r[REG_A] | b;
		end else if (sub) begin
			s = ia - ib - ic;
			res = 8'(s);
			carry = s < 0; // Borrow.
		end else begin
			s = ia + ib + ic;
			res = 8'(s);
			carry = s > 255;
		end
		m_f = 8'h00;
		m_f[FLAG_Z] = res == 8'h00;
		m_f[FLAG_N] = sub;
		m_f[FLAG_C] = carry;
		if (op != ALU_CP) m_r[REG_A] = res;
	endtask

	function automatic logic cond_holds(input logic [1:0] cc);
		case (cc)
			2'd0: return !m_f[FLAG_Z];
			2'd1: return m_f[FLAG_Z];
			2'd2: return !m_f[FLAG_C];
			default: return m_f[FLAG_C];
		endcase
	endfunction

	task automatic run_model;
		logic [15:0] pc;
		logic [15:0] hl;
		logic [7:0]  op;
		logic [7:0]  lo;
		logic [7:0]  hi;
		logic [1:0]  x;
		logic [2:0]  y;
		logic [2:0]  z;
		bit          done;
		int          steps;
		for (int a = 0; a < 65536; a++) begin
			model_mem[a] = mem[a];
		end
		for (int i = 0; i < 8; i++) begin
			m_r[i] = 8'h00;
		end
		m_f = 8'h00;
		m_sp = 16'h0000;
		pc = RESET_PC;
		done = 0;
		steps = 0;
		while (!done && steps < 4 * N_SLOTS) begin
			steps++;
			op = model_mem[pc];
			expect_cycle(pc, 1'b0, op);
			pc = pc + 16'd1;
			x = op[7:6];
			y = op[5:3];
			z = op[2:0];
			if (op == OP_HALT) begin
				done = 1;
			end else if (x == 2'd1 && y == REG_MEM) begin
				hl = {m_r[REG_H], m_r[REG_L]};
				expect_cycle(hl, 1'b1, m_r[z]);
				model_mem[hl] = m_r[z];
			end else if (x == 2'd1) begin
				m_r[y] = m_r[z];
			end else if (x == 2'd0 && z == 3'd6) begin
				m_r[y] = model_mem[pc];
				expect_cycle(pc, 1'b0, model_mem[pc]);
				pc = pc + 16'd1;
			end else if (x == 2'd0 && z == 3'd1) begin
				lo = model_mem[pc];
				expect_cycle(pc, 1'b0, lo);
				hi = model_mem[pc + 16'd1];
				expect_cycle(pc + 16'd1, 1'b0, hi);
				pc = pc + 16'd2;
				case (op[5:4])
					2'd0: begin
						m_r[REG_B] = hi;
						m_r[REG_C] = lo;
					end
					2'd1: begin
						m_r[REG_D] = hi;
						m_r[REG_E] = lo;
					end
					2'd2: begin
						m_r[REG_H] = hi;
						m_r[REG_L] = lo;
					end
					default: m_sp = {hi, lo};
				endcase
			end else if (x == 2'd2) begin
				run_alu(y, m_r[z]);
			end else if (x == 2'd3 && z == 3'd6) begin
				run_alu(y, model_mem[pc]);
				expect_cycle(pc, 1'b0, model_mem[pc]);
				pc = pc + 16'd1;
			end else if (x == 2'd3 && (z == 3'd2 || z == 3'd3)) begin
				lo = model_mem[pc];
				expect_cycle(pc, 1'b0, lo);
				hi = model_mem[pc + 16'd1];
				expect_cycle(pc + 16'd1, 1'b0, hi);
				pc = pc + 16'd2;
				if (op == OP_JP || cond_holds(y[1:0])) pc = {hi, lo};
			end
		end
	endtask

	task automatic bus_cycle_done;
		logic [15:0] e_adr;
		logic        e_wr;
		logic [7:0]  e_data;
		if (!first_done) begin
			first_done = 1;
			check_value("adr", adr, RESET_PC);
			check_value("wr", 16'(wr), 16'd0);
			check_value("halted", 16'(halted), 16'd0);
		end
		if (exp_adr.size() == 0) begin
			errors++;
			$display("Unexpected bus cycle at address %h after the program ended", adr);
		end else begin
			e_adr = exp_adr.pop_front();
			e_wr = exp_wr.pop_front();
			e_data = exp_data.pop_front();
			check_value("adr", adr, e_adr);
			check_value("rd", 16'(rd), 16'(!e_wr));
			check_value("wr", 16'(wr), 16'(e_wr));
			if (e_wr) check_value("dout", 16'(dout), 16'(e_data));
		end
	endtask

	// Outputs settled after the rising edge, so they are sampled here and
	// describe the cycle that completes at the next rising edge.
	always @(negedge clk) begin
		if (areset) begin
			reset_count++;
			if (reset_count == 2) areset = 1'b0;
		end
		if (areset) begin
			ready = 1'b1;
			din = mem[adr];
		end else begin
			ready = ($urandom % 4) != 0;
			din = mem[adr];
			if (halted && (rd || wr)) begin
				errors++;
				$display("Bus strobe seen while halted at address %h", adr);
			end
			if (ready && (rd || wr)) begin
				bus_cycle_done();
				if (wr) mem[adr] = dout;
			end
		end
	end

	initial begin
		areset = 1'b1;
		ready = 1'b1;
		din = 8'h00;
		errors = 0;
		reset_count = 0;
		first_done = 0;
		void'($urandom(32'h2d8843d1));
		build_program();
		run_model();
		fork
			begin
				repeat (WATCHDOG_CYCLES) @(posedge clk);
				$display("Watchdog expired before the core halted, errors: %0d", errors);
				$display("Testbench failed");
				$finish;
			end
		join_none
		wait (halted === 1'b1);
		if (exp_adr.size() != 0) begin
			errors++;
			$display("Core halted with %0d predicted bus cycles outstanding", exp_adr.size());
		end
		repeat (50) @(posedge clk);
		check_value("halted", 16'(halted), 16'd1);
		$display("Errors: %0d", errors);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

// File: sm83_core.f
rtl/sm83_pkg.sv
rtl/sm83_io.sv
rtl/sm83_control.sv
rtl/sm83_regfile.sv
rtl/sm83_alu.sv
rtl/sm83_core.sv
sim/sm83_core_sva.sv
sim/sm83_core_tb.sv
